//--- Makefile
# verilator flow for the core slice

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module core_top

sim:
	verilator --binary --timing --assert -j 0 -f build.f --top-module core_tb -Mdir obj_dir
	./obj_dir/Vcore_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- build.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/gpr_file.sv
hdl/id_decoder.sv
hdl/id_reg.sv
hdl/shift_add_mul.sv
hdl/mul_counter.sv
hdl/pipe_ctrl.sv
hdl/ex_stage.sv
hdl/core_top.sv
verif/core_tb.sv

//--- hdl/core_top.sv
// ------------------------------
// core slice top level
// decode, id/ex register, ex stage, register file
// and the multiply controller
// ------------------------------
`timescale 1ns/1ps

module core_top import isa_pkg::*, pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [31:0]           instr,
	input  logic                  instr_valid,
	input  logic                  flush,
	output logic                  stall,        // fetch holds instr while high
	output logic                  retire_valid,
	output logic                  retire_we,
	output logic [REG_ADDR_W-1:0] retire_addr,
	output logic [WORD_W-1:0]     retire_data
);

	// decode <-> gpr / bypass
	logic [REG_ADDR_W-1:0] rs_addr, rt_addr;
	logic [WORD_W-1:0]     rs_data, rt_data;
	logic                  fwd_we;
	logic [REG_ADDR_W-1:0] fwd_addr;
	logic [WORD_W-1:0]     fwd_data;
	// decode -> id/ex
	logic                  en, gpr_we;
	alu_op_e               alu_op;
	mem_op_e               mem_op;
	logic [WORD_W-1:0]     alu_in_0, alu_in_1, mem_wr_data;
	logic [REG_ADDR_W-1:0] dst_addr;
	// id/ex -> ex
	logic                  id_en, id_gpr_we;
	alu_op_e               id_alu_op;
	mem_op_e               id_mem_op;
	logic [WORD_W-1:0]     id_alu_in_0, id_alu_in_1, id_mem_wr_data;
	logic [REG_ADDR_W-1:0] id_dst_addr;
	// write-back and multiply control
	logic                  wb_we;
	logic [REG_ADDR_W-1:0] wb_addr;
	logic [WORD_W-1:0]     wb_data;
	logic                  mul_req, mul_start, mul_step, mul_done, last_step;

	id_decoder i_id_decoder (
		.instr, .instr_valid, .rs_addr, .rt_addr, .rs_data, .rt_data,
		.fwd_we, .fwd_addr, .fwd_data, .en, .alu_op, .alu_in_0, .alu_in_1,
		.mem_op, .mem_wr_data, .dst_addr, .gpr_we
	);

	gpr_file i_gpr_file (
		.clk, .rst_n, .rs_addr, .rt_addr, .rs_data, .rt_data,
		.we (wb_we), .wr_addr (wb_addr), .wr_data (wb_data)
	);

	id_reg i_id_reg (
		.clk, .rst_n, .stall, .flush, .if_en (en), .alu_op, .alu_in_0,
		.alu_in_1, .mem_op, .mem_wr_data, .dst_addr, .gpr_we, .id_en,
		.id_alu_op, .id_alu_in_0, .id_alu_in_1, .id_mem_op, .id_mem_wr_data,
		.id_dst_addr, .id_gpr_we
	);

	ex_stage i_ex_stage (
		.clk, .rst_n, .id_en, .id_alu_op, .id_alu_in_0, .id_alu_in_1,
		.id_mem_op, .id_mem_wr_data, .id_dst_addr, .id_gpr_we, .mul_start,
		.mul_step, .mul_done, .mul_req, .fwd_we, .fwd_addr, .fwd_data,
		.gpr_we (wb_we), .gpr_addr (wb_addr), .gpr_data (wb_data),
		.retire_valid, .retire_we, .retire_addr, .retire_data
	);

	pipe_ctrl i_pipe_ctrl (
		.clk, .rst_n, .mul_req, .last_step, .mul_start, .mul_step,
		.mul_done, .stall
	);

	mul_counter i_mul_counter (
		.clk, .rst_n, .load (mul_start), .dec (mul_step), .last_step
	);

endmodule

//--- hdl/ex_stage.sv
// ------------------------------
// ex stage
// alu, data memory, multiplier hookup and the
// registered retire / write-back of each instruction
// ------------------------------
`timescale 1ns/1ps

module ex_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  id_en,
	input  alu_op_e               id_alu_op,
	input  logic [WORD_W-1:0]     id_alu_in_0,
	input  logic [WORD_W-1:0]     id_alu_in_1,
	input  mem_op_e               id_mem_op,
	input  logic [WORD_W-1:0]     id_mem_wr_data,
	input  logic [REG_ADDR_W-1:0] id_dst_addr,
	input  logic                  id_gpr_we,
	input  logic                  mul_start,
	input  logic                  mul_step,
	input  logic                  mul_done,
	output logic                  mul_req,
	output logic                  fwd_we,        // bypass to decode
	output logic [REG_ADDR_W-1:0] fwd_addr,
	output logic [WORD_W-1:0]     fwd_data,
	output logic                  gpr_we,        // gpr write port
	output logic [REG_ADDR_W-1:0] gpr_addr,
	output logic [WORD_W-1:0]     gpr_data,
	output logic                  retire_valid,
	output logic                  retire_we,
	output logic [REG_ADDR_W-1:0] retire_addr,
	output logic [WORD_W-1:0]     retire_data
);

	logic [WORD_W-1:0]      dmem [DMEM_DEPTH];
	logic [WORD_W-1:0]      alu_res;
	logic [WORD_W-1:0]      product;
	logic [WORD_W-1:0]      wb_data;
	logic [DMEM_ADDR_W-1:0] dmem_addr;
	logic                   is_mul;
	logic                   mul_fin;   // mul retired, id/ex not yet reloaded
	logic                   wb_fire;   // instruction completes this cycle
	logic                   wb_we;

	shift_add_mul i_shift_add_mul (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (mul_start),
		.step    (mul_step),
		.a       (id_alu_in_0),
		.b       (id_alu_in_1),
		.product (product)
	);

	always_comb begin
		case (id_alu_op)
			ALU_ADD:    alu_res = id_alu_in_0 + id_alu_in_1;
			ALU_SUB:    alu_res = id_alu_in_0 - id_alu_in_1;
			ALU_AND:    alu_res = id_alu_in_0 & id_alu_in_1;
			ALU_OR:     alu_res = id_alu_in_0 | id_alu_in_1;
			ALU_XOR:    alu_res = id_alu_in_0 ^ id_alu_in_1;
			ALU_PASS_B: alu_res = id_alu_in_1;
			default:    alu_res = '0;  // nop, mul goes through product
		endcase
	end

	assign dmem_addr = alu_res[DMEM_ADDR_W+1:2];  // word index
	assign is_mul    = id_en && (id_alu_op == ALU_MUL);
	assign mul_req   = is_mul && !mul_fin;
	assign wb_fire   = id_en && (!is_mul || mul_done);
	assign wb_we     = wb_fire && id_gpr_we;

	// load data, product or alu result
	assign wb_data = (id_mem_op == MEM_LOAD) ? dmem[dmem_addr] :
	                 is_mul                  ? product : alu_res;

	assign fwd_we   = wb_we;
	assign fwd_addr = id_dst_addr;
	assign fwd_data = wb_data;
	assign gpr_we   = wb_we;  // written at the retire edge
	assign gpr_addr = id_dst_addr;
	assign gpr_data = wb_data;

	// ------------------------------
	// retire regs and store
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
			retire_we    <= 1'b0;
			retire_addr  <= '0;
			retire_data  <= '0;
			mul_fin      <= 1'b0;
		end else begin
			retire_valid <= wb_fire;
			mul_fin      <= mul_done;  // covers the one cycle id/ex still holds it
			if (wb_fire) begin
				retire_we   <= wb_we;
				retire_addr <= id_dst_addr;
				retire_data <= wb_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wb_fire && (id_mem_op == MEM_STORE)) begin
			dmem[dmem_addr] <= id_mem_wr_data;
		end
	end

endmodule

//--- hdl/gpr_file.sv
// ------------------------------
// general purpose register file
// 32 x 32, two async reads, one sync write, r0 fixed zero
// ------------------------------
`timescale 1ns/1ps

module gpr_file import isa_pkg::*, pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] rs_addr,  // read port 0
	input  logic [REG_ADDR_W-1:0] rt_addr,  // read port 1
	output logic [WORD_W-1:0]     rs_data,
	output logic [WORD_W-1:0]     rt_data,
	input  logic                  we,       // write port, from ex
	input  logic [REG_ADDR_W-1:0] wr_addr,
	input  logic [WORD_W-1:0]     wr_data
);

	logic [WORD_W-1:0] regs [2**REG_ADDR_W];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wr_addr != '0)) begin  // r0 never written
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

//--- hdl/id_decoder.sv
// ------------------------------
// instruction decoder
// maps opcode to alu, memory and write-back controls,
// picks operands and applies the ex bypass
// ------------------------------
`timescale 1ns/1ps

module id_decoder import isa_pkg::*, pipe_pkg::*; (
	input  logic [31:0]           instr,
	input  logic                  instr_valid,
	output logic [REG_ADDR_W-1:0] rs_addr,      // to gpr file
	output logic [REG_ADDR_W-1:0] rt_addr,
	input  logic [WORD_W-1:0]     rs_data,
	input  logic [WORD_W-1:0]     rt_data,
	input  logic                  fwd_we,       // ex write-back this cycle
	input  logic [REG_ADDR_W-1:0] fwd_addr,
	input  logic [WORD_W-1:0]     fwd_data,
	output logic                  en,
	output alu_op_e               alu_op,
	output logic [WORD_W-1:0]     alu_in_0,
	output logic [WORD_W-1:0]     alu_in_1,
	output mem_op_e               mem_op,
	output logic [WORD_W-1:0]     mem_wr_data,
	output logic [REG_ADDR_W-1:0] dst_addr,
	output logic                  gpr_we
);

	opcode_e           opc;
	logic [IMM_W-1:0]  imm;
	logic [WORD_W-1:0] imm_sext;   // addi, lw, sw
	logic [WORD_W-1:0] imm_upper;  // lui
	logic [WORD_W-1:0] rs_val;     // after bypass
	logic [WORD_W-1:0] rt_val;

	assign opc       = opcode_e'(instr[OPC_MSB:OPC_LSB]);
	assign imm       = instr[IMM_W-1:0];
	assign imm_sext  = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
	assign imm_upper = {imm, {(WORD_W-IMM_W){1'b0}}};
	assign dst_addr  = instr[RD_LSB +: REG_ADDR_W];
	assign en        = instr_valid;

	// sw reads its store data from the rd field
	assign rs_addr = instr[RS_LSB +: REG_ADDR_W];
	assign rt_addr = (opc == OP_SW) ? instr[RD_LSB +: REG_ADDR_W] : instr[RT_LSB +: REG_ADDR_W];

	// bypass from ex, r0 never forwarded
	assign rs_val = (fwd_we && (fwd_addr == rs_addr) && (rs_addr != '0)) ? fwd_data : rs_data;
	assign rt_val = (fwd_we && (fwd_addr == rt_addr) && (rt_addr != '0)) ? fwd_data : rt_data;

	assign alu_in_0    = rs_val;
	assign mem_wr_data = rt_val;

	// ------------------------------
	// control decode
	// ------------------------------
	always_comb begin
		alu_op   = ALU_NOP;  // unknown opcodes land here
		alu_in_1 = rt_val;
		mem_op   = MEM_NOP;
		gpr_we   = 1'b0;
		case (opc)
			OP_ADD:  begin alu_op = ALU_ADD; gpr_we = instr_valid; end
			OP_SUB:  begin alu_op = ALU_SUB; gpr_we = instr_valid; end
			OP_AND:  begin alu_op = ALU_AND; gpr_we = instr_valid; end
			OP_OR:   begin alu_op = ALU_OR;  gpr_we = instr_valid; end
			OP_XOR:  begin alu_op = ALU_XOR; gpr_we = instr_valid; end
			OP_MUL:  begin alu_op = ALU_MUL; gpr_we = instr_valid; end
			OP_ADDI: begin
				alu_op   = ALU_ADD;
				alu_in_1 = imm_sext;
				gpr_we   = instr_valid;
			end
			OP_LUI: begin
				alu_op   = ALU_PASS_B;
				alu_in_1 = imm_upper;
				gpr_we   = instr_valid;
			end
			OP_LW: begin
				alu_op   = ALU_ADD;  // effective address
				alu_in_1 = imm_sext;
				mem_op   = MEM_LOAD;
				gpr_we   = instr_valid;
			end
			OP_SW: begin
				alu_op   = ALU_ADD;
				alu_in_1 = imm_sext;
				mem_op   = MEM_STORE;  // retires with we low
			end
			default: ;  // nop, retires without write
		endcase
	end

endmodule

//--- hdl/id_reg.sv
// ------------------------------
// id/ex stage register
// holds on stall, takes a bubble on flush or reset,
// otherwise latches the decode results
// ------------------------------
`timescale 1ns/1ps

module id_reg import isa_pkg::*, pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,           // from pipe ctrl
	input  logic                  flush,           // ignored while stalled
	input  logic                  if_en,           // instr valid
	// decode results
	input  alu_op_e               alu_op,
	input  logic [WORD_W-1:0]     alu_in_0,
	input  logic [WORD_W-1:0]     alu_in_1,
	input  mem_op_e               mem_op,
	input  logic [WORD_W-1:0]     mem_wr_data,
	input  logic [REG_ADDR_W-1:0] dst_addr,
	input  logic                  gpr_we,          // active high
	// to ex
	output logic                  id_en,
	output alu_op_e               id_alu_op,
	output logic [WORD_W-1:0]     id_alu_in_0,
	output logic [WORD_W-1:0]     id_alu_in_1,
	output mem_op_e               id_mem_op,
	output logic [WORD_W-1:0]     id_mem_wr_data,
	output logic [REG_ADDR_W-1:0] id_dst_addr,
	output logic                  id_gpr_we
);

	logic bubble;  // reset or flush, load nop defaults

	assign bubble = !rst_n || (!stall && flush);

	always_ff @(posedge clk) begin
		if (bubble) begin
			id_en          <= 1'b0;
			id_alu_op      <= ALU_NOP;
			id_alu_in_0    <= '0;
			id_alu_in_1    <= '0;
			id_mem_op      <= MEM_NOP;
			id_mem_wr_data <= '0;
			id_dst_addr    <= '0;
			id_gpr_we      <= 1'b0;
		end else if (!stall) begin  // hold otherwise
			id_en          <= if_en;
			id_alu_op      <= alu_op;
			id_alu_in_0    <= alu_in_0;
			id_alu_in_1    <= alu_in_1;
			id_mem_op      <= mem_op;
			id_mem_wr_data <= mem_wr_data;
			id_dst_addr    <= dst_addr;
			id_gpr_we      <= gpr_we;
		end
	end

endmodule

//--- hdl/isa_pkg.sv
// ------------------------------
// isa package
// opcode encoding, instruction field positions and
// the register address width of the core
// ------------------------------
package isa_pkg;

	// instruction word fields
	localparam int OPC_MSB    = 31;  // opcode top bit
	localparam int OPC_LSB    = 26;  // opcode low bit
	localparam int RD_LSB     = 21;  // dest reg, 5 bits
	localparam int RS_LSB     = 16;  // first source
	localparam int RT_LSB     = 11;  // second source, overlaps imm
	localparam int IMM_W      = 16;  // imm in [15:0]
	localparam int REG_ADDR_W = 5;   // 32 gprs

	// ------------------------------
	// opcodes
	// ------------------------------
	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_ADDI = 6'h06,  // rd = rs + sext(imm)
		OP_LUI  = 6'h07,  // rd = imm << 16
		OP_LW   = 6'h08,  // rd = mem[rs + sext(imm)]
		OP_SW   = 6'h09,  // mem[rs + sext(imm)] = rd
		OP_MUL  = 6'h0a   // rd = low word of rs * rt
	} opcode_e;

endpackage

//--- hdl/mul_counter.sv
// ------------------------------
// multiply step counter
// loadable down counter, flags the last step
// ------------------------------
`timescale 1ns/1ps

module mul_counter import pipe_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic load,       // mul_start
	input  logic dec,        // mul_step
	output logic last_step
);

	logic [MUL_CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= MUL_CNT_W'(MUL_STEPS - 1);
		end else if (dec && (cnt != '0)) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign last_step = (cnt == '0);

endmodule

//--- hdl/pipe_ctrl.sv
// ------------------------------
// pipeline controller
// starts the multiply, enables its steps and stalls
// the front end until the last step
// ------------------------------
`timescale 1ns/1ps

module pipe_ctrl import pipe_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic mul_req,    // valid mul in id/ex
	input  logic last_step,  // from counter
	output logic mul_start,
	output logic mul_step,
	output logic mul_done,
	output logic stall
);

	ctrl_state_e state;
	ctrl_state_e state_next;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_RUN;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_RUN:  if (mul_req) state_next = ST_MUL;
			ST_MUL:  if (last_step) state_next = ST_RUN;
			default: state_next = ST_RUN;
		endcase
	end

	assign mul_start = (state == ST_RUN) && mul_req;  // one cycle
	assign mul_step  = (state == ST_MUL);
	assign mul_done  = (state == ST_MUL) && last_step;
	assign stall     = mul_start || mul_step;          // request cycle through done

endmodule

//--- hdl/pipe_pkg.sv
// ------------------------------
// pipeline package
// data width, ex stage operation codes, controller
// states and multiplier / data memory sizes
// ------------------------------
package pipe_pkg;

	localparam int WORD_W = 32;  // data word

	// alu operation, decided in id
	typedef enum logic [2:0] {
		ALU_NOP    = 3'd0,
		ALU_ADD    = 3'd1,
		ALU_SUB    = 3'd2,
		ALU_AND    = 3'd3,
		ALU_OR     = 3'd4,
		ALU_XOR    = 3'd5,
		ALU_PASS_B = 3'd6,  // lui
		ALU_MUL    = 3'd7   // iterative, not in the alu proper
	} alu_op_e;

	// data memory access
	typedef enum logic [1:0] {
		MEM_NOP   = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_op_e;

	// multiply controller
	typedef enum logic {
		ST_RUN = 1'b0,  // normal issue
		ST_MUL = 1'b1   // stepping the multiplier
	} ctrl_state_e;

	localparam int MUL_STEPS   = 32;  // one per multiplier bit
	localparam int MUL_CNT_W   = 6;
	localparam int DMEM_DEPTH  = 16;  // words
	localparam int DMEM_ADDR_W = 4;   // word index, addr bits [5:2]

endpackage

//--- hdl/shift_add_mul.sv
// ------------------------------
// shift-and-add multiplier
// one partial product per enabled step, low word kept
// ------------------------------
`timescale 1ns/1ps

module shift_add_mul import pipe_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,    // load operands
	input  logic              step,     // one bit per cycle
	input  logic [WORD_W-1:0] a,        // multiplicand
	input  logic [WORD_W-1:0] b,        // multiplier
	output logic [WORD_W-1:0] product   // valid in last step cycle
);

	logic [WORD_W-1:0] mcand;
	logic [WORD_W-1:0] mplier;
	logic [WORD_W-1:0] acc;
	logic [WORD_W-1:0] acc_next;

	// accumulator after the current step
	assign acc_next = mplier[0] ? (acc + mcand) : acc;
	assign product  = acc_next;  // last step result seen same cycle

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mcand  <= '0;
			mplier <= '0;
			acc    <= '0;
		end else if (start) begin
			mcand  <= a;
			mplier <= b;
			acc    <= '0;
		end else if (step) begin
			acc    <= acc_next;
			mcand  <= mcand << 1;   // upper bits fall off
			mplier <= mplier >> 1;
		end
	end

endmodule

//--- verif/core_tb.sv
// ------------------------------
// core slice testbench
// directed tests against a golden isa model, an
// in-order retire checker and a cycle watchdog
// ------------------------------
`timescale 1ns/1ps

module core_tb import isa_pkg::*, pipe_pkg::*; ();

	typedef struct packed {
		logic                  we;
		logic [REG_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     data;
		logic                  timed;   // retire cycle fixed for non-mul
		int                    at_cyc;
	} retire_t;

	logic                  clk;
	logic                  rst_n;
	logic [31:0]           instr;
	logic                  instr_valid;
	logic                  flush;
	logic                  stall;
	logic                  retire_valid;
	logic                  retire_we;
	logic [REG_ADDR_W-1:0] retire_addr;
	logic [WORD_W-1:0]     retire_data;

	logic [WORD_W-1:0] model_regs [2**REG_ADDR_W];  // golden gprs
	logic [WORD_W-1:0] model_mem [DMEM_DEPTH];      // golden dmem
	retire_t           exp_q [$];                   // program order
	int                cyc = 0;
	int                n_issued = 0;
	int                n_retired = 0;
	integer            seed;
	string             test_name;

	core_top i_core_top (
		.clk, .rst_n, .instr, .instr_valid, .flush, .stall,
		.retire_valid, .retire_we, .retire_addr, .retire_data
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns
	end

	always @(posedge clk) cyc <= cyc + 1;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// ------------------------------
	// instruction builders
	// ------------------------------
	function automatic logic [31:0] r_instr(input logic [5:0] op,
			input logic [REG_ADDR_W-1:0] rd, input logic [REG_ADDR_W-1:0] rs,
			input logic [REG_ADDR_W-1:0] rt);
		return {op, rd, rs, rt, 11'd0};
	endfunction

	function automatic logic [31:0] i_instr(input logic [5:0] op,
			input logic [REG_ADDR_W-1:0] rd, input logic [REG_ADDR_W-1:0] rs,
			input logic [IMM_W-1:0] imm);
		return {op, rd, rs, imm};
	endfunction

	function automatic logic [5:0] alu_op_for(input int k);
		case (k % 5)
			0:       return OP_ADD;
			1:       return OP_SUB;
			2:       return OP_AND;
			3:       return OP_OR;
			default: return OP_XOR;
		endcase
	endfunction

	// golden isa model in issue order
	task automatic model_exec(input logic [31:0] w, output retire_t r);
		logic [5:0]            op;
		logic [REG_ADDR_W-1:0] rd;
		logic [WORD_W-1:0]     a, b, sext, ea, res;
		op   = w[OPC_MSB:OPC_LSB];
		rd   = w[RD_LSB +: REG_ADDR_W];
		a    = model_regs[w[RS_LSB +: REG_ADDR_W]];
		b    = model_regs[w[RT_LSB +: REG_ADDR_W]];
		sext = {{(WORD_W-IMM_W){w[IMM_W-1]}}, w[IMM_W-1:0]};
		ea   = a + sext;
		res  = '0;
		r    = '0;
		r.we   = 1'b1;
		r.addr = rd;
		case (op)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_ADDI: res = a + sext;
			OP_LUI:  res = {w[IMM_W-1:0], 16'h0000};
			OP_LW:   res = model_mem[ea[DMEM_ADDR_W+1:2]];  // word index
			OP_MUL:  res = a * b;                           // low word only
			OP_SW: begin
				model_mem[ea[DMEM_ADDR_W+1:2]] = model_regs[rd];
				r.we = 1'b0;
			end
			default: r.we = 1'b0;  // nop and unknown opcodes
		endcase
		r.data = res;
		if (r.we && (rd != '0)) model_regs[rd] = res;
	endtask

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	task automatic issue(input logic [31:0] w, input logic fl, input logic fl_in_stall);
		retire_t r;
		logic    taken;
		instr       = w;
		instr_valid = 1'b1;
		n_issued++;
		taken = 1'b0;
		while (!taken) begin
			taken = !stall;                     // stable 1 ns after the edge
			flush = taken ? fl : fl_in_stall;
			@(posedge clk);
			#1;
		end
		instr_valid = 1'b0;
		flush       = 1'b0;
		if (!fl) begin  // squashed ones never retire
			model_exec(w, r);
			r.timed  = (w[OPC_MSB:OPC_LSB] != OP_MUL);
			r.at_cyc = cyc + 1;                // edge after the id/ex latch
			exp_q.push_back(r);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			instr = rand32();  // garbage while valid is low
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0) && (waited < MUL_STEPS + 8)) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (exp_q.size() != 0) begin
			fail_run($sformatf("%0d expected retires never arrived in test %s",
				exp_q.size(), test_name));
		end
		idle(2);  // room for a stray retire
	endtask

	task automatic load_rand(input logic [REG_ADDR_W-1:0] rd);
		logic [31:0] rnd;
		rnd = rand32();
		issue(i_instr(OP_LUI, rd, 5'd0, rnd[31:16]), 1'b0, 1'b0);
		issue(i_instr(OP_ADDI, rd, rd, rnd[15:0]), 1'b0, 1'b0);
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic test_alu();
		logic [31:0] rnd;
		test_name = "alu";
		issue(r_instr(OP_ADD, 5'd5, 5'd20, 5'd21), 1'b0, 1'b0);  // regs clear after reset
		for (int i = 1; i < 9; i++) load_rand(5'(i));
		for (int i = 0; i < 20; i++) begin
			rnd = rand32();
			issue(r_instr(alu_op_for(i), rnd[4:0], rnd[9:5], rnd[14:10]), 1'b0, 1'b0);
		end
		rnd = rand32();
		issue(i_instr(OP_ADDI, 5'd9, rnd[9:5], rnd[31:16]), 1'b0, 1'b0);
		issue(i_instr(OP_LUI, 5'd10, 5'd0, rnd[15:0]), 1'b0, 1'b0);
		issue(i_instr(OP_ADDI, 5'd0, 5'd1, 16'h1234), 1'b0, 1'b0);  // r0 write dropped
		issue(r_instr(OP_OR, 5'd6, 5'd0, 5'd0), 1'b0, 1'b0);
		drain();
	endtask

	task automatic test_chain();
		logic [REG_ADDR_W-1:0] prev;
		logic [REG_ADDR_W-1:0] prev2;
		logic [REG_ADDR_W-1:0] dst;
		logic [31:0]           rnd;
		test_name = "chain";
		rnd = rand32();
		issue(i_instr(OP_ADDI, 5'd1, 5'd1, rnd[15:0]), 1'b0, 1'b0);
		prev  = 5'd1;
		prev2 = 5'd2;
		for (int i = 0; i < 12; i++) begin
			dst = 5'(2 + i % 7);
			issue(r_instr(alu_op_for(i), dst, prev, prev2), 1'b0, 1'b0);  // rs from ex bypass
			prev2 = prev;
			prev  = dst;
		end
		drain();
	endtask

	task automatic test_mem();
		logic [31:0] rnd;
		int          idx;
		test_name = "mem";
		for (int i = 1; i < 9; i++) load_rand(5'(i));
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			issue(i_instr(OP_SW, 5'(1 + i % 8), 5'd0, 16'(4 * i)), 1'b0, 1'b0);
		end
		issue(i_instr(OP_ADDI, 5'd10, 5'd0, 16'h0040), 1'b0, 1'b0);  // base for negative offsets
		for (int i = 0; i < 16; i++) begin
			rnd = rand32();
			idx = int'(rnd[3:0]);
			issue(i_instr(OP_LW, 5'(11 + i % 4), 5'd10, 16'(4 * idx - 64)), 1'b0, 1'b0);
		end
		issue(i_instr(OP_SW, 5'd12, 5'd0, 16'h0014), 1'b0, 1'b0);
		issue(i_instr(OP_LW, 5'd13, 5'd0, 16'h0014), 1'b0, 1'b0);  // right behind the store
		drain();
	endtask

	task automatic test_mul();
		test_name = "mul";
		for (int k = 0; k < 3; k++) begin
			load_rand(5'd1);
			load_rand(5'd2);
			issue(r_instr(OP_MUL, 5'd4, 5'd1, 5'd2), 1'b0, 1'b0);
			assert (stall === 1'b1)
			else fail_run("stall stayed low while a multiply was running");
			issue(r_instr(OP_ADD, 5'd5, 5'd4, 5'd3), 1'b0, 1'b0);  // held until the product lands
		end
		issue(r_instr(OP_MUL, 5'd6, 5'd4, 5'd5), 1'b0, 1'b0);
		issue(r_instr(OP_MUL, 5'd7, 5'd6, 5'd6), 1'b0, 1'b0);  // back to back
		issue(r_instr(OP_SUB, 5'd8, 5'd7, 5'd6), 1'b0, 1'b0);
		drain();
	endtask

	task automatic test_flush();
		test_name = "flush";
		issue(r_instr(OP_ADD, 5'd7, 5'd1, 5'd2), 1'b0, 1'b0);
		issue(r_instr(OP_XOR, 5'd7, 5'd7, 5'd7), 1'b1, 1'b0);    // squashed so r7 is kept
		issue(r_instr(OP_SUB, 5'd8, 5'd7, 5'd1), 1'b0, 1'b0);
		issue(i_instr(OP_SW, 5'd8, 5'd0, 16'h0008), 1'b1, 1'b0);  // squashed store
		issue(i_instr(OP_LW, 5'd9, 5'd0, 16'h0008), 1'b0, 1'b0);
		// flush high only while the multiply stalls
		issue(r_instr(OP_MUL, 5'd4, 5'd7, 5'd8), 1'b0, 1'b0);
		issue(r_instr(OP_ADD, 5'd5, 5'd4, 5'd4), 1'b0, 1'b1);
		drain();
	endtask

	task automatic test_bubble();
		logic [31:0] rnd;
		test_name = "bubble";
		idle(6);
		rnd = rand32();
		issue(i_instr(6'h3f, 5'd3, 5'd1, rnd[15:0]), 1'b0, 1'b0);  // unknown opcode
		idle(3);
		issue(r_instr(6'h20, 5'd3, 5'd1, 5'd2), 1'b0, 1'b0);
		issue(r_instr(OP_NOP, 5'd3, 5'd1, 5'd2), 1'b0, 1'b0);
		issue(r_instr(OP_ADD, 5'd4, 5'd3, 5'd0), 1'b0, 1'b0);  // r3 untouched
		idle(4);
		drain();
	endtask

	// ------------------------------
	// retire checker
	// ------------------------------
	always @(negedge clk) begin
		retire_t e;
		if (rst_n && retire_valid) begin
			if (exp_q.size() == 0) begin
				fail_run($sformatf("retire strobe in test %s with no instruction pending",
					test_name));
			end else begin
				e = exp_q.pop_front();
				n_retired++;
				assert (retire_we === e.we)
				else fail_run($sformatf("error %s retire %0d we: expected %0b actual %0b",
					test_name, n_retired, e.we, retire_we));
				if (e.we) begin
					assert (retire_addr === e.addr)
					else fail_run($sformatf("error %s retire %0d addr: expected %0d actual %0d",
						test_name, n_retired, e.addr, retire_addr));
					assert (retire_data === e.data)
					else fail_run($sformatf("error %s retire %0d data: expected %h actual %h",
						test_name, n_retired, e.data, retire_data));
				end
				if (e.timed) begin
					assert (cyc == e.at_cyc)
					else fail_run($sformatf("error %s retire %0d cycle: expected %0d actual %0d",
						test_name, n_retired, e.at_cyc, cyc));
				end
			end
		end
	end

	// watchdog budget grows with every issued instruction
	initial begin
		wait (cyc > n_issued * (MUL_STEPS + 4) + 200);
		fail_run($sformatf("timeout in test %s after %0d cycles", test_name, cyc));
	end

	initial begin
		seed        = 32'h10db_5ef6;
		rst_n       = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		flush       = 1'b0;
		test_name   = "reset";
		for (int i = 0; i < 2**REG_ADDR_W; i++) model_regs[i] = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_alu();
		test_chain();
		test_mem();
		test_mul();
		test_flush();
		test_bubble();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
